// File: verilog/asi_params.svh
`ifndef ASI_PARAMS_SVH
`define ASI_PARAMS_SVH

////////////////////
// FIFO sizing
////////////////////

// Depth must stay a power of two, pointers wrap on their own
`define ASI_FIFO_DEPTH 16
`define ASI_FIFO_AW 4

////////////////////
// Widths and codes
////////////////////

`define ASI_BYTE_W 8
`define ASI_SYM_W 10

// K28.5 byte value and its two symbols, abcdei fghj with a at bit 9
`define ASI_K28_5_BYTE 8'hbc
`define ASI_K28_5_NEG 10'b0011111010
`define ASI_K28_5_POS 10'b1100000101

`endif

// File: verilog/asi_pkg.sv
`include "asi_params.svh"

package asi_pkg;

	////////////////////
	// Plain vectors
	////////////////////

	// One transport-stream byte
	typedef logic [`ASI_BYTE_W-1:0] ts_byte_t;

	// Encoded symbol, abcdei in [9:4], fghj in [3:0]
	typedef logic [`ASI_SYM_W-1:0] asi_sym_t;

	typedef logic [5:0] code6_t;
	typedef logic [3:0] code4_t;

	////////////////////
	// Structs
	////////////////////

	// Character waiting for the encoders
	typedef struct packed {
		logic     is_k;
		ts_byte_t data;
	} asi_char_t;

	// 5b/6b result, code in the form for negative entry disparity
	typedef struct packed {
		code6_t code;
		logic   unbal;
		logic   flip_pos;
	} sub6_t;

	// 3b/4b result; alt marks a character that may take the A7 form 0111
	typedef struct packed {
		code4_t code;
		logic   alt;
		logic   x7;
		logic   unbal;
		logic   flip_pos;
	} sub4_t;

endpackage

// File: verilog/ts_byte_fifo.sv
`timescale 1ns/100ps
`include "asi_params.svh"

module ts_byte_fifo (
	input  logic               din_clk,
	input  logic               rst_n,
	input  logic               valid,
	input  asi_pkg::ts_byte_t  din_8b,
	input  logic               ce,
	output asi_pkg::asi_char_t chr,
	output logic               chr_stb,
	output logic               error_full
);

	localparam logic [`ASI_FIFO_AW:0] depth_cnt = `ASI_FIFO_DEPTH;

	asi_pkg::ts_byte_t       mem [`ASI_FIFO_DEPTH];
	logic [`ASI_FIFO_AW-1:0] wr_ptr;
	logic [`ASI_FIFO_AW-1:0] rd_ptr;
	logic [`ASI_FIFO_AW:0]   count;
	logic                    full;
	logic                    empty;
	logic                    wr_en;
	logic                    rd_en;

	assign full  = (count == depth_cnt);
	assign empty = (count == '0);

	// Byte dropped while full, flagged in the same cycle
	assign wr_en      = valid & ~full;
	assign rd_en      = ce & ~empty;
	assign error_full = valid & full;

	////////////////////
	// Storage
	////////////////////

	always_ff @(posedge din_clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= din_8b;
		end
	end

	always_ff @(posedge din_clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	////////////////////
	// Output stage
	////////////////////

	// Empty slot becomes K28.5 idle fill
	always_ff @(posedge din_clk) begin
		if (ce) begin
			if (rd_en) begin
				chr <= '{is_k: 1'b0, data: mem[rd_ptr]};
			end else begin
				chr <= '{is_k: 1'b1, data: `ASI_K28_5_BYTE};
			end
		end
	end

	always_ff @(posedge din_clk) begin
		if (!rst_n) begin
			chr_stb <= 1'b0;
		end else begin
			chr_stb <= ce;
		end
	end

endmodule

// File: verilog/enc_5b6b.sv
`timescale 1ns/100ps
`include "asi_params.svh"

module enc_5b6b (
	input  asi_pkg::asi_char_t chr,
	output asi_pkg::sub6_t     s6
);

	localparam asi_pkg::asi_sym_t k_neg = `ASI_K28_5_NEG;

	asi_pkg::code6_t code;

	// Negative-form abcdei codes
	always_comb begin
		case (chr.data[4:0])
			5'd0:    code = 6'b100111;
			5'd1:    code = 6'b011101;
			5'd2:    code = 6'b101101;
			5'd3:    code = 6'b110001;
			5'd4:    code = 6'b110101;
			5'd5:    code = 6'b101001;
			5'd6:    code = 6'b011001;
			5'd7:    code = 6'b111000;
			5'd8:    code = 6'b111001;
			5'd9:    code = 6'b100101;
			5'd10:   code = 6'b010101;
			5'd11:   code = 6'b110100;
			5'd12:   code = 6'b001101;
			5'd13:   code = 6'b101100;
			5'd14:   code = 6'b011100;
			5'd15:   code = 6'b010111;
			5'd16:   code = 6'b011011;
			5'd17:   code = 6'b100011;
			5'd18:   code = 6'b010011;
			5'd19:   code = 6'b110010;
			5'd20:   code = 6'b001011;
			5'd21:   code = 6'b101010;
			5'd22:   code = 6'b011010;
			5'd23:   code = 6'b111010;
			5'd24:   code = 6'b110011;
			5'd25:   code = 6'b100110;
			5'd26:   code = 6'b010110;
			5'd27:   code = 6'b110110;
			5'd28:   code = 6'b001110;
			5'd29:   code = 6'b101110;
			5'd30:   code = 6'b011110;
			default: code = 6'b101011;
		endcase
	end

	always_comb begin
		if (chr.is_k) begin
			// K28 block, always unbalanced
			s6.code     = k_neg[9:4];
			s6.unbal    = 1'b1;
			s6.flip_pos = 1'b0;
		end else begin
			s6.code     = code;
			s6.unbal    = ($countones(code) != 3);
			// D.7 is balanced yet alternates
			s6.flip_pos = (chr.data[4:0] == 5'd7);
		end
	end

endmodule

// File: verilog/enc_3b4b.sv
`timescale 1ns/100ps
`include "asi_params.svh"

module enc_3b4b (
	input  asi_pkg::asi_char_t chr,
	output asi_pkg::sub4_t     s4
);

	localparam asi_pkg::asi_sym_t k_pos = `ASI_K28_5_POS;

	asi_pkg::code4_t code;
	logic [4:0]      x;
	logic [2:0]      y;

	assign x = chr.data[4:0];
	assign y = chr.data[7:5];

	// Negative-form fghj codes, x.7 as the primary form
	always_comb begin
		case (y)
			3'd0:    code = 4'b1011;
			3'd1:    code = 4'b1001;
			3'd2:    code = 4'b0101;
			3'd3:    code = 4'b1100;
			3'd4:    code = 4'b1101;
			3'd5:    code = 4'b1010;
			3'd6:    code = 4'b0110;
			default: code = 4'b1110;
		endcase
	end

	always_comb begin
		if (chr.is_k) begin
			// K28.5 follows an unbalanced K28 block, so it flips on the
			// disparity it meets there: 0101 at negative, 1010 at positive
			s4.code     = k_pos[3:0];
			s4.alt      = 1'b0;
			s4.x7       = 1'b0;
			s4.unbal    = 1'b0;
			s4.flip_pos = 1'b1;
		end else begin
			s4.code     = code;
			// Only these x values can end their 6b block in a run of two
			s4.alt      = (x == 5'd11) || (x == 5'd13) || (x == 5'd14) ||
			              (x == 5'd17) || (x == 5'd18) || (x == 5'd20);
			s4.x7       = (y == 3'd7);
			s4.unbal    = (y == 3'd0) || (y == 3'd4) || (y == 3'd7);
			s4.flip_pos = (y == 3'd3);
		end
	end

endmodule

// File: verilog/disparity_combiner.sv
`timescale 1ns/100ps

module disparity_combiner (
	input  logic              din_clk,
	input  logic              rst_n,
	input  asi_pkg::sub6_t    s6,
	input  asi_pkg::sub4_t    s4,
	input  logic              chr_stb,
	output asi_pkg::asi_sym_t sym,
	output logic              sym_valid
);

	// Running disparity, high when positive
	logic rd;
	logic rd_mid;
	logic rd_next;

	asi_pkg::code6_t c6;
	asi_pkg::code4_t c4_sel;
	asi_pkg::code4_t c4;
	logic            use_a7;

	////////////////////
	// 6-bit block
	////////////////////

	always_comb begin
		if (rd && (s6.unbal || s6.flip_pos)) begin
			c6 = ~s6.code;
		end else begin
			c6 = s6.code;
		end
		rd_mid = s6.unbal ? ~rd : rd;
	end

	////////////////////
	// 4-bit block
	////////////////////

	// A7 avoids a run of five across the e i f g h boundary
	always_comb begin
		if (rd_mid) begin
			use_a7 = s4.x7 && s4.alt && (c6[1:0] == 2'b00);
		end else begin
			use_a7 = s4.x7 && s4.alt && (c6[1:0] == 2'b11);
		end
		c4_sel = use_a7 ? 4'b0111 : s4.code;
		if (rd_mid && (s4.unbal || s4.flip_pos)) begin
			c4 = ~c4_sel;
		end else begin
			c4 = c4_sel;
		end
		rd_next = s4.unbal ? ~rd_mid : rd_mid;
	end

	////////////////////
	// Registers
	////////////////////

	always_ff @(posedge din_clk) begin
		if (chr_stb) begin
			sym <= {c6, c4};
		end
	end

	always_ff @(posedge din_clk) begin
		if (!rst_n) begin
			rd        <= 1'b0;
			sym_valid <= 1'b0;
		end else begin
			sym_valid <= chr_stb;
			if (chr_stb) begin
				rd <= rd_next;
			end
		end
	end

endmodule

// File: verilog/ts2asi.sv
`timescale 1ns/100ps

module ts2asi (
	input  logic              din_clk,
	input  logic              rst_n,
	input  logic              valid,
	input  asi_pkg::ts_byte_t din_8b,
	input  logic              ce,
	output asi_pkg::asi_sym_t sym,
	output logic              sym_valid,
	output logic              error_full
);

	asi_pkg::asi_char_t chr;
	logic               chr_stb;
	asi_pkg::sub6_t     s6;
	asi_pkg::sub4_t     s4;

	// Byte queue and idle insertion
	ts_byte_fifo u_fifo (
		.din_clk    (din_clk),
		.rst_n      (rst_n),
		.valid      (valid),
		.din_8b     (din_8b),
		.ce         (ce),
		.chr        (chr),
		.chr_stb    (chr_stb),
		.error_full (error_full)
	);

	// Sub-block lookups, same character
	enc_5b6b u_enc6 (
		.chr (chr),
		.s6  (s6)
	);

	enc_3b4b u_enc4 (
		.chr (chr),
		.s4  (s4)
	);

	// Polarity choice and symbol register
	disparity_combiner u_comb (
		.din_clk   (din_clk),
		.rst_n     (rst_n),
		.s6        (s6),
		.s4        (s4),
		.chr_stb   (chr_stb),
		.sym       (sym),
		.sym_valid (sym_valid)
	);

endmodule

// File: bench/ts2asi_checker.sv
`timescale 1ns/100ps

module ts2asi_checker (
	input logic              din_clk,
	input logic              rst_n,
	input logic              ce,
	input asi_pkg::asi_sym_t sym,
	input logic              sym_valid,
	input logic              error_full
);

	logic seen_ce;
	// Sign of the line after the last unbalanced symbol
	logic last_pos;

	function automatic int longest_run(input asi_pkg::asi_sym_t s);
		int best;
		int run;
		int i;
		best = 1;
		run  = 1;
		for (i = 1; i < 10; i++) begin
			if (s[i] == s[i-1]) begin
				run++;
			end else begin
				run = 1;
			end
			if (run > best) begin
				best = run;
			end
		end
		return best;
	endfunction

	always_ff @(posedge din_clk) begin
		if (!rst_n) begin
			seen_ce  <= 1'b0;
			last_pos <= 1'b0;
		end else begin
			if (ce) begin
				seen_ce <= 1'b1;
			end
			if (sym_valid && ($countones(sym) != 5)) begin
				last_pos <= ($countones(sym) == 6);
			end
		end
	end

	////////////////////
	// Properties
	////////////////////

	a_quiet_before_ce: assert property (@(posedge din_clk) disable iff (!rst_n)
		!seen_ce |-> (!sym_valid && !error_full))
		else $error("Output activity before the first symbol slot");

	// Two cycles from slot to symbol, back-to-back slots too
	a_latency: assert property (@(posedge din_clk) disable iff (!rst_n)
		sym_valid == $past(ce, 2))
		else $error("sym_valid does not follow ce by two cycles");

	a_ones: assert property (@(posedge din_clk) disable iff (!rst_n)
		sym_valid |-> ($countones(sym) >= 4 && $countones(sym) <= 6))
		else $error("Symbol with an illegal number of ones");

	a_alternate: assert property (@(posedge din_clk) disable iff (!rst_n)
		(sym_valid && ($countones(sym) != 5)) |-> (($countones(sym) == 6) != last_pos))
		else $error("Unbalanced symbol does not reverse the running disparity");

	a_run_length: assert property (@(posedge din_clk) disable iff (!rst_n)
		sym_valid |-> (longest_run(sym) <= 5))
		else $error("Run of more than five equal bits inside a symbol");

endmodule

// File: bench/ts2asi_tb.sv
`timescale 1ns/100ps
`include "asi_params.svh"

module ts2asi_tb;

	localparam int clk_period      = 20;
	localparam int reset_cycles    = 8;
	localparam int idle_cycles     = 40;
	localparam int count_cycles    = 400;
	localparam int rand_cycles     = 800;
	localparam int burst_cycles    = 60;
	localparam int drain_cycles    = 80;
	localparam int tail_cycles     = 4;
	localparam int watchdog_cycles = reset_cycles + idle_cycles + count_cycles + rand_cycles +
	                                 burst_cycles + drain_cycles + tail_cycles + 200;

	localparam asi_pkg::asi_char_t k_char = {1'b1, `ASI_K28_5_BYTE};

	// 8b/10b table in the form for negative disparity, indexed by x and by y
	localparam logic [5:0] code6 [32] = '{
		6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
		6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
		6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
		6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
	};
	localparam logic [3:0] code4 [8] = '{
		4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110
	};

	logic               din_clk;
	logic               rst_n;
	logic               valid;
	asi_pkg::ts_byte_t  din_8b;
	logic               ce;
	asi_pkg::asi_sym_t  sym;
	logic               sym_valid;
	logic               error_full;

	// Reference model state
	asi_pkg::ts_byte_t  model_q [$];
	asi_pkg::asi_char_t exp_q [$];
	asi_pkg::asi_char_t exp_c;
	asi_pkg::asi_char_t got_c;
	logic               line_rd;
	logic               dec_ok;
	logic               full_now;
	logic               stim_done;
	int                 err_cnt;
	int                 check_cnt;
	logic [31:0]        rnd;
	asi_pkg::ts_byte_t  cnt;

	ts2asi u_dut (
		.din_clk    (din_clk),
		.rst_n      (rst_n),
		.valid      (valid),
		.din_8b     (din_8b),
		.ce         (ce),
		.sym        (sym),
		.sym_valid  (sym_valid),
		.error_full (error_full)
	);

	bind ts2asi ts2asi_checker u_chk (
		.din_clk    (din_clk),
		.rst_n      (rst_n),
		.ce         (ce),
		.sym        (sym),
		.sym_valid  (sym_valid),
		.error_full (error_full)
	);

	initial begin
		din_clk = 1'b0;
		forever #(clk_period / 2) din_clk = ~din_clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] v);
		logic [31:0] r;
		r = v ^ (v << 13);
		r = r ^ (r >> 17);
		r = r ^ (r << 5);
		return r;
	endfunction

	task automatic drive_cycle(input logic v, input asi_pkg::ts_byte_t d, input logic c);
		@(posedge din_clk);
		#2;
		valid  = v;
		din_8b = d;
		ce     = c;
	endtask

	////////////////////
	// Symbol decode
	////////////////////

	// Search the table for the form legal at the model's disparity
	task automatic decode_sym(
		input  asi_pkg::asi_sym_t  s,
		output logic               ok,
		output asi_pkg::asi_char_t chr_out
	);
		logic [5:0] f6;
		logic [3:0] f4;
		logic       rd_mid;
		logic       rd_end;
		logic       a7;
		logic       hit6;
		logic       hit4;
		logic [4:0] x;
		logic [2:0] y;
		int         i;
		hit6   = 1'b0;
		hit4   = 1'b0;
		x      = '0;
		y      = '0;
		rd_mid = line_rd;
		rd_end = line_rd;
		if (s == (line_rd ? `ASI_K28_5_POS : `ASI_K28_5_NEG)) begin
			ok      = 1'b1;
			chr_out = k_char;
			line_rd = ~line_rd;
		end else begin
			for (i = 0; i < 32; i++) begin
				f6 = code6[i];
				if (line_rd && (($countones(f6) != 3) || (i == 7))) begin
					f6 = ~f6;
				end
				if (f6 == s[9:4]) begin
					hit6   = 1'b1;
					x      = i[4:0];
					rd_mid = line_rd ^ ($countones(f6) != 3);
				end
			end
			// x.7 takes 0111 where e i f g h would otherwise run to five
			a7 = rd_mid ? (s[5:4] == 2'b00) : (s[5:4] == 2'b11);
			for (i = 0; i < 8; i++) begin
				f4 = ((i == 7) && a7) ? 4'b0111 : code4[i];
				if (rd_mid && (($countones(f4) != 2) || (i == 3))) begin
					f4 = ~f4;
				end
				if (f4 == s[3:0]) begin
					hit4   = 1'b1;
					y      = i[2:0];
					rd_end = rd_mid ^ ($countones(f4) != 2);
				end
			end
			ok      = hit6 && hit4;
			chr_out = {1'b0, y, x};
			if (ok) begin
				line_rd = rd_end;
			end
		end
	endtask

	////////////////////
	// Monitor
	////////////////////

	// Inputs and outputs are both settled at the falling edge
	always @(negedge din_clk) begin
		if (!rst_n) begin
			line_rd = 1'b0;
		end else begin
			if (sym_valid) begin
				check_cnt++;
				assert (exp_q.size() != 0) else begin
					err_cnt++;
					$display("Symbol %h came out with no character pending", sym);
				end
				if (exp_q.size() != 0) begin
					exp_c = exp_q.pop_front();
					decode_sym(sym, dec_ok, got_c);
					assert (dec_ok) else begin
						err_cnt++;
						$display("Symbol %h is no legal code at running disparity %0d",
						         sym, line_rd);
					end
					assert (!dec_ok || (got_c == exp_c)) else begin
						err_cnt++;
						$display("ERROR sym: decoded %h expected %h", got_c, exp_c);
					end
				end
			end
			full_now = (model_q.size() == `ASI_FIFO_DEPTH);
			check_cnt++;
			assert (error_full == (valid && full_now)) else begin
				err_cnt++;
				$display("ERROR error_full: got %h expected %h", error_full, valid && full_now);
			end
			// Pop before push, a same-cycle write is not yet readable
			if (ce) begin
				if (model_q.size() != 0) begin
					exp_q.push_back({1'b0, model_q.pop_front()});
				end else begin
					exp_q.push_back(k_char);
				end
			end
			if (valid && !full_now) begin
				model_q.push_back(din_8b);
			end
			if (stim_done) begin
				check_cnt++;
				assert ((exp_q.size() == 0) && (model_q.size() == 0)) else begin
					err_cnt++;
					$display("Run ended with %0d bytes queued and %0d symbols owed",
					         model_q.size(), exp_q.size());
				end
			end
		end
	end

	initial begin
		#(watchdog_cycles * clk_period);
		$display("Watchdog expired after %0d cycles without the run completing", watchdog_cycles);
		$display("Finished with errors");
		$finish;
	end

	////////////////////
	// Stimulus
	////////////////////

	initial begin
		int c;
		rst_n     = 1'b0;
		valid     = 1'b0;
		din_8b    = '0;
		ce        = 1'b0;
		stim_done = 1'b0;
		err_cnt   = 0;
		check_cnt = 0;
		cnt       = '0;
		rnd       = 32'hd264_e311;
		repeat (reset_cycles) @(posedge din_clk);
		#2;
		rst_n = 1'b1;
		// Idle line, K28.5 only
		for (c = 0; c < idle_cycles; c++) begin
			drive_cycle(1'b0, '0, (c % 2) == 0);
		end
		// Counter bytes with a slot on every cycle
		for (c = 0; c < count_cycles; c++) begin
			drive_cycle((c % 4) != 3, cnt, 1'b1);
			if ((c % 4) != 3) begin
				cnt = cnt + 1'b1;
			end
		end
		// Random bytes kept below the slot rate
		for (c = 0; c < rand_cycles; c++) begin
			rnd = xorshift32(rnd);
			drive_cycle(((c % 4) != 3) && rnd[8], rnd[7:0], (c % 2) == 0);
		end
		// Burst overruns the FIFO
		for (c = 0; c < burst_cycles; c++) begin
			rnd = xorshift32(rnd);
			drive_cycle(1'b1, rnd[7:0], (c % 2) == 0);
		end
		for (c = 0; c < drain_cycles; c++) begin
			drive_cycle(1'b0, '0, (c % 2) == 0);
		end
		repeat (tail_cycles) drive_cycle(1'b0, '0, 1'b0);
		stim_done = 1'b1;
		@(negedge din_clk);
		#1;
		$display("Checks run: %0d, errors counted: %0d", check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// File: verilog.f
+incdir+verilog
verilog/asi_pkg.sv
verilog/ts_byte_fifo.sv
verilog/enc_5b6b.sv
verilog/enc_3b4b.sv
verilog/disparity_combiner.sv
verilog/ts2asi.sv
bench/ts2asi_checker.sv
bench/ts2asi_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the ts2asi testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module ts2asi_tb \
	-f verilog.f \
	-o ts2asi_sim

# A stopped simulation still leaves its log for the check below
./obj_dir/ts2asi_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Finished with no errors" sim.log; then
	echo "Simulation PASSED"
else
	echo "Simulation FAILED"
	exit 1
fi
